// ==== src/rtab_pkg.sv ====
/*
 * Replay table package
 * Field widths, dependency bit positions and the pop-try FSM state type
 */
package rtab_pkg;

    // Cache-line index width
    localparam int NLINE_W = 12;

    // Request id width
    localparam int ID_W = 8;

    // Number of dependency bits per entry
    localparam int DEP_W = 2;

    // Waiting for the refill of the same cache line
    localparam int DEP_MSHR_HIT = 0;

    // Waiting for the miss handler to become ready
    localparam int DEP_MSHR_READY = 1;

    // Pop-try FSM
    // HEAD offers list heads, NEXT and NEXT_WAIT walk a list toward its tail
    typedef enum logic [1:0] {
        POP_TRY_HEAD      = 2'd0,
        POP_TRY_NEXT      = 2'd1,
        POP_TRY_NEXT_WAIT = 2'd2
    } pop_state_e;

endpackage

// ==== src/rtab_entry_store.sv ====
/*
 * Replay table entry array
 * Valid, head, tail and next-pointer state, allocation, check, commit and rollback
 */
`timescale 1ns/10ps

module rtab_entry_store #(
    parameter int N_ENTRIES = 8,
    localparam int PTR_W = $clog2(N_ENTRIES),
    localparam int CNT_W = $clog2(N_ENTRIES + 1)
) (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic                                   alloc_i,
    input  logic                                   alloc_and_link_i,
    input  logic [rtab_pkg::NLINE_W-1:0]           alloc_nline_i,
    input  logic [rtab_pkg::ID_W-1:0]              alloc_id_i,
    input  logic                                   check_i,
    input  logic [rtab_pkg::NLINE_W-1:0]           check_nline_i,
    input  logic                                   pop_try_i,
    input  logic [PTR_W-1:0]                       pop_ptr_i,
    input  logic                                   pop_commit_i,
    input  logic [PTR_W-1:0]                       pop_commit_ptr_i,
    input  logic                                   pop_rback_i,
    input  logic [PTR_W-1:0]                       pop_rback_ptr_i,
    output logic                                   check_hit_o,
    output logic [rtab_pkg::NLINE_W-1:0]           pop_nline_o,
    output logic [rtab_pkg::ID_W-1:0]              pop_id_o,
    output logic [N_ENTRIES-1:0]                   head_ready_o,
    output logic [N_ENTRIES-1:0]                   tail_o,
    output logic [N_ENTRIES*PTR_W-1:0]             next_ptrs_o,
    output logic [N_ENTRIES*rtab_pkg::NLINE_W-1:0] entry_nlines_o,
    output logic [N_ENTRIES-1:0]                   alloc_slot_o,
    output logic                                   empty_o,
    output logic                                   full_o,
    output logic [CNT_W-1:0]                       usage_o
);
    import rtab_pkg::*;

    // Payload array
    logic [N_ENTRIES-1:0][NLINE_W-1:0] nline_q;
    logic [N_ENTRIES-1:0][ID_W-1:0]    id_q;

    // Control state
    logic [N_ENTRIES-1:0]              valid_q;
    logic [N_ENTRIES-1:0]              head_q;
    logic [N_ENTRIES-1:0]              tail_q;
    logic [N_ENTRIES-1:0][PTR_W-1:0]   next_q;

    logic                 alloc;
    logic [N_ENTRIES-1:0] free;
    logic [PTR_W-1:0]     alloc_ptr;
    logic [N_ENTRIES-1:0] alloc_set;
    logic [N_ENTRIES-1:0] check_hit;
    logic [N_ENTRIES-1:0] match_tail;
    logic [N_ENTRIES-1:0] try_bv;
    logic [N_ENTRIES-1:0] commit_bv;
    logic [N_ENTRIES-1:0] rback_bv;
    logic [N_ENTRIES-1:0] succ_bv;
    logic [N_ENTRIES-1:0] head_set;
    logic [N_ENTRIES-1:0] head_rst;
    logic [N_ENTRIES-1:0] tail_rst;

    assign alloc = alloc_i | alloc_and_link_i;

    // Lowest free entry, one-hot
    assign free         = ~valid_q;
    assign alloc_slot_o = free & ~(free - N_ENTRIES'(1));
    assign alloc_set    = alloc_slot_o & {N_ENTRIES{alloc}};

    always_comb begin : alloc_enc
        alloc_ptr = '0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (alloc_slot_o[i]) begin
                alloc_ptr = PTR_W'(i);
            end
        end
    end

    // Overlap check against every valid entry
    for (genvar i = 0; i < N_ENTRIES; i++) begin : gen_check
        assign check_hit[i] = valid_q[i] && (nline_q[i] == check_nline_i);
    end
    assign check_hit_o = |check_hit;
    assign match_tail  = check_hit & tail_q;

    // Pointer decodes for pop try, commit and rollback
    assign try_bv    = {N_ENTRIES{pop_try_i}} & (N_ENTRIES'(1) << pop_ptr_i);
    assign commit_bv = {N_ENTRIES{pop_commit_i}} & (N_ENTRIES'(1) << pop_commit_ptr_i);
    assign rback_bv  = {N_ENTRIES{pop_rback_i}} & (N_ENTRIES'(1) << pop_rback_ptr_i);

    // Committing a non-tail hands the head over to its successor
    assign succ_bv = (pop_commit_i && !tail_q[pop_commit_ptr_i]) ?
                     (N_ENTRIES'(1) << next_q[pop_commit_ptr_i]) : '0;

    // Plain allocation opens a new list, a link entry starts without head
    assign head_set = (alloc_set & {N_ENTRIES{alloc_i}}) | rback_bv | succ_bv;
    // Pop try blocks rescheduling, even of a successor getting head this cycle
    assign head_rst = try_bv | commit_bv;
    assign tail_rst = (match_tail & {N_ENTRIES{alloc_and_link_i}}) | commit_bv;

    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_ff
        if (!rst_ni) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            next_q  <= '0;
        end else begin
            valid_q <= (valid_q | alloc_set) & ~commit_bv;
            head_q  <= (head_q | head_set) & ~head_rst;
            tail_q  <= (tail_q | alloc_set) & ~tail_rst;
            // Old tail points to the linked entry
            for (int i = 0; i < N_ENTRIES; i++) begin
                if (alloc_and_link_i && match_tail[i]) begin
                    next_q[i] <= alloc_ptr;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin : payload_ff
        for (int i = 0; i < N_ENTRIES; i++) begin
            if (alloc_set[i]) begin
                nline_q[i] <= alloc_nline_i;
                id_q[i]    <= alloc_id_i;
            end
        end
    end

    // Offered entry data
    assign pop_nline_o = nline_q[pop_ptr_i];
    assign pop_id_o    = id_q[pop_ptr_i];

    assign head_ready_o   = valid_q & head_q;
    assign tail_o         = tail_q;
    assign next_ptrs_o    = next_q;
    assign entry_nlines_o = nline_q;

    // Status
    assign empty_o = ~|valid_q;
    assign full_o  = &valid_q;

    always_comb begin : usage_cnt
        usage_o = '0;
        for (int i = 0; i < N_ENTRIES; i++) begin
            usage_o = usage_o + CNT_W'(valid_q[i]);
        end
    end

    // A line has a single list, so a single tail
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        check_i |-> $onehot0(match_tail))
        else $error("rtab: several tails match the checked nline");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc |-> !full_o)
        else $error("rtab: allocation while full");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_and_link_i |-> (check_i && check_hit_o))
        else $error("rtab: link allocation without check hit");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (pop_commit_i |-> valid_q[pop_commit_ptr_i]) and
        (pop_rback_i |-> valid_q[pop_rback_ptr_i]))
        else $error("rtab: commit or rollback of an invalid entry");

endmodule

// ==== src/rtab_deps_tracker.sv ====
/*
 * Replay table dependency bits
 * Load on allocation and rollback, clear on refill and miss-handler ready
 */
`timescale 1ns/10ps

module rtab_deps_tracker #(
    parameter int N_ENTRIES = 8,
    localparam int PTR_W = $clog2(N_ENTRIES)
) (
    input  logic                                   clk_i,
    input  logic                                   rst_ni,
    input  logic [N_ENTRIES-1:0]                   alloc_slot_i,
    input  logic                                   alloc_i,
    input  logic                                   alloc_and_link_i,
    input  logic [rtab_pkg::DEP_W-1:0]             alloc_deps_i,
    input  logic                                   pop_rback_i,
    input  logic [PTR_W-1:0]                       pop_rback_ptr_i,
    input  logic [N_ENTRIES*rtab_pkg::NLINE_W-1:0] entry_nlines_i,
    input  logic                                   refill_i,
    input  logic [rtab_pkg::NLINE_W-1:0]           refill_nline_i,
    input  logic                                   miss_ready_i,
    output logic [N_ENTRIES-1:0]                   nodeps_o
);
    import rtab_pkg::*;

    logic [N_ENTRIES-1:0][DEP_W-1:0] deps_q;
    logic [N_ENTRIES-1:0]            load;
    logic [N_ENTRIES-1:0]            refill_hit;

    // Entries loaded this cycle, allocation slot or rolled-back entry
    assign load = (alloc_slot_i & {N_ENTRIES{alloc_i | alloc_and_link_i}}) |
                  ({N_ENTRIES{pop_rback_i}} & (N_ENTRIES'(1) << pop_rback_ptr_i));

    for (genvar i = 0; i < N_ENTRIES; i++) begin : gen_entry
        assign refill_hit[i] = refill_i &&
                               (entry_nlines_i[i*NLINE_W +: NLINE_W] == refill_nline_i);
        assign nodeps_o[i]   = ~|deps_q[i];
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : deps_ff
        if (!rst_ni) begin
            deps_q <= '0;
        end else begin
            for (int i = 0; i < N_ENTRIES; i++) begin
                // Load wins over a clear in the same cycle
                if (load[i]) begin
                    deps_q[i] <= alloc_deps_i;
                end else begin
                    if (refill_hit[i]) begin
                        deps_q[i][DEP_MSHR_HIT] <= 1'b0;
                    end
                    if (miss_ready_i) begin
                        deps_q[i][DEP_MSHR_READY] <= 1'b0;
                    end
                end
            end
        end
    end

    // Rollback and allocation share alloc_deps_i
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_rback_i |-> !(alloc_i || alloc_and_link_i))
        else $error("rtab: rollback during allocation");

endmodule

// ==== src/rtab_pop_ctrl.sv ====
/*
 * Replay table pop control
 * Round-robin choice among ready list heads and the list-walk FSM
 */
`timescale 1ns/10ps

module rtab_pop_ctrl #(
    parameter int N_ENTRIES = 8,
    localparam int PTR_W = $clog2(N_ENTRIES)
) (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  logic [N_ENTRIES-1:0]       head_ready_i,
    input  logic [N_ENTRIES-1:0]       nodeps_i,
    input  logic [N_ENTRIES-1:0]       tail_i,
    input  logic [N_ENTRIES*PTR_W-1:0] next_ptrs_i,
    input  logic                       pop_try_i,
    input  logic                       pop_rback_i,
    output logic                       pop_try_valid_o,
    output logic [PTR_W-1:0]           pop_ptr_o
);
    import rtab_pkg::*;

    pop_state_e           state_q, state_d;
    logic [PTR_W-1:0]     walk_ptr_q, walk_ptr_d;
    logic [PTR_W-1:0]     rr_q;
    logic [N_ENTRIES-1:0] ready;
    logic                 gnt_any;
    logic [PTR_W-1:0]     gnt_ptr;
    logic                 take_head;
    logic                 cur_is_tail;
    logic [PTR_W-1:0]     cur_next;

    // Replayable heads
    assign ready = head_ready_i & nodeps_i;

    // Round-robin search, starting just after the last granted entry
    always_comb begin : rr_pick
        int idx;
        gnt_any = 1'b0;
        gnt_ptr = '0;
        for (int k = 1; k <= N_ENTRIES; k++) begin
            idx = int'(rr_q) + k;
            if (idx >= N_ENTRIES) begin
                idx = idx - N_ENTRIES;
            end
            if (!gnt_any && ready[idx]) begin
                gnt_any = 1'b1;
                gnt_ptr = PTR_W'(idx);
            end
        end
    end

    // Entry on offer and where its list continues
    assign pop_ptr_o   = (state_q == POP_TRY_HEAD) ? gnt_ptr : walk_ptr_q;
    assign cur_is_tail = tail_i[pop_ptr_o];
    assign cur_next    = next_ptrs_i[pop_ptr_o*PTR_W +: PTR_W];

    always_comb begin : valid_comb
        case (state_q)
            POP_TRY_HEAD:      pop_try_valid_o = gnt_any;
            POP_TRY_NEXT:      pop_try_valid_o = 1'b1;
            POP_TRY_NEXT_WAIT: pop_try_valid_o = 1'b1;
            default:           pop_try_valid_o = 1'b0;
        endcase
    end

    always_comb begin : fsm_comb
        state_d    = state_q;
        walk_ptr_d = walk_ptr_q;
        take_head  = 1'b0;
        case (state_q)
            POP_TRY_HEAD: begin
                // A head taken off a longer list starts the walk
                if (pop_try_i && !pop_rback_i && gnt_any) begin
                    take_head = 1'b1;
                    if (!cur_is_tail) begin
                        state_d    = POP_TRY_NEXT;
                        walk_ptr_d = cur_next;
                    end
                end
            end
            POP_TRY_NEXT, POP_TRY_NEXT_WAIT: begin
                // Rollback of the previous member aborts the walk
                if (pop_rback_i && (state_q == POP_TRY_NEXT)) begin
                    state_d = POP_TRY_HEAD;
                end else if (pop_try_i) begin
                    if (cur_is_tail) begin
                        state_d = POP_TRY_HEAD;
                    end else begin
                        state_d    = POP_TRY_NEXT;
                        walk_ptr_d = cur_next;
                    end
                end else begin
                    // Hold the offered member until taken
                    state_d = POP_TRY_NEXT_WAIT;
                end
            end
            default: begin
                state_d = POP_TRY_HEAD;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : fsm_ff
        if (!rst_ni) begin
            state_q    <= POP_TRY_HEAD;
            walk_ptr_q <= '0;
            rr_q       <= PTR_W'(N_ENTRIES - 1);
        end else begin
            state_q    <= state_d;
            walk_ptr_q <= walk_ptr_d;
            if (take_head) begin
                rr_q <= gnt_ptr;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_try_i |-> (pop_try_valid_o && !pop_rback_i))
        else $error("rtab: pop try while nothing offered or during rollback");

endmodule

// ==== src/rtab_top.sv ====
/*
 * Replay table top level
 * Entry store, dependency tracker and pop controller
 */
`timescale 1ns/10ps

module rtab_top #(
    parameter int N_ENTRIES = 8,
    localparam int PTR_W = $clog2(N_ENTRIES),
    localparam int CNT_W = $clog2(N_ENTRIES + 1)
) (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    // Allocation
    input  logic                         alloc_i,
    input  logic                         alloc_and_link_i,
    input  logic [rtab_pkg::NLINE_W-1:0] alloc_nline_i,
    input  logic [rtab_pkg::ID_W-1:0]    alloc_id_i,
    input  logic [rtab_pkg::DEP_W-1:0]   alloc_deps_i,
    // Check
    input  logic                         check_i,
    input  logic [rtab_pkg::NLINE_W-1:0] check_nline_i,
    output logic                         check_hit_o,
    // Pop, commit and rollback
    output logic                         pop_try_valid_o,
    input  logic                         pop_try_i,
    output logic [rtab_pkg::NLINE_W-1:0] pop_try_nline_o,
    output logic [rtab_pkg::ID_W-1:0]    pop_try_id_o,
    output logic [PTR_W-1:0]             pop_try_ptr_o,
    input  logic                         pop_commit_i,
    input  logic [PTR_W-1:0]             pop_commit_ptr_i,
    input  logic                         pop_rback_i,
    input  logic [PTR_W-1:0]             pop_rback_ptr_i,
    // Refill and miss handler events
    input  logic                         refill_i,
    input  logic [rtab_pkg::NLINE_W-1:0] refill_nline_i,
    input  logic                         miss_ready_i,
    // Status
    output logic                         empty_o,
    output logic                         full_o,
    output logic [CNT_W-1:0]             usage_o
);
    import rtab_pkg::*;

    logic [N_ENTRIES-1:0]         head_ready;
    logic [N_ENTRIES-1:0]         tail;
    logic [N_ENTRIES*PTR_W-1:0]   next_ptrs;
    logic [N_ENTRIES*NLINE_W-1:0] entry_nlines;
    logic [N_ENTRIES-1:0]         alloc_slot;
    logic [N_ENTRIES-1:0]         nodeps;

    rtab_entry_store #(
        .N_ENTRIES (N_ENTRIES)
    ) store_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .alloc_i          (alloc_i),
        .alloc_and_link_i (alloc_and_link_i),
        .alloc_nline_i    (alloc_nline_i),
        .alloc_id_i       (alloc_id_i),
        .check_i          (check_i),
        .check_nline_i    (check_nline_i),
        .pop_try_i        (pop_try_i),
        .pop_ptr_i        (pop_try_ptr_o),
        .pop_commit_i     (pop_commit_i),
        .pop_commit_ptr_i (pop_commit_ptr_i),
        .pop_rback_i      (pop_rback_i),
        .pop_rback_ptr_i  (pop_rback_ptr_i),
        .check_hit_o      (check_hit_o),
        .pop_nline_o      (pop_try_nline_o),
        .pop_id_o         (pop_try_id_o),
        .head_ready_o     (head_ready),
        .tail_o           (tail),
        .next_ptrs_o      (next_ptrs),
        .entry_nlines_o   (entry_nlines),
        .alloc_slot_o     (alloc_slot),
        .empty_o          (empty_o),
        .full_o           (full_o),
        .usage_o          (usage_o)
    );

    rtab_deps_tracker #(
        .N_ENTRIES (N_ENTRIES)
    ) deps_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .alloc_slot_i     (alloc_slot),
        .alloc_i          (alloc_i),
        .alloc_and_link_i (alloc_and_link_i),
        .alloc_deps_i     (alloc_deps_i),
        .pop_rback_i      (pop_rback_i),
        .pop_rback_ptr_i  (pop_rback_ptr_i),
        .entry_nlines_i   (entry_nlines),
        .refill_i         (refill_i),
        .refill_nline_i   (refill_nline_i),
        .miss_ready_i     (miss_ready_i),
        .nodeps_o         (nodeps)
    );

    rtab_pop_ctrl #(
        .N_ENTRIES (N_ENTRIES)
    ) pop_i (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .head_ready_i    (head_ready),
        .nodeps_i        (nodeps),
        .tail_i          (tail),
        .next_ptrs_i     (next_ptrs),
        .pop_try_i       (pop_try_i),
        .pop_rback_i     (pop_rback_i),
        .pop_try_valid_o (pop_try_valid_o),
        .pop_ptr_o       (pop_try_ptr_o)
    );

endmodule

// ==== verification/rtab_tb_checks.svh ====
/*
 * Replay table testbench helpers
 * Typed compare tasks, offer wait with timeout and the failure exit
 */
`ifndef RTAB_TB_CHECKS_SVH
`define RTAB_TB_CHECKS_SVH

// Reports the problem and ends the run
task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "testbench stopped at the first error");
endtask

task automatic compare_nline(input string name, input logic [NLINE_W-1:0] exp_v,
                             input logic [NLINE_W-1:0] act_v);
    if (act_v !== exp_v) begin
        stop_on_error($sformatf("FAIL at %0t ns: %s expected %h, actual %h",
                                $time, name, exp_v, act_v));
    end
endtask

task automatic compare_id(input string name, input logic [ID_W-1:0] exp_v,
                          input logic [ID_W-1:0] act_v);
    if (act_v !== exp_v) begin
        stop_on_error($sformatf("FAIL at %0t ns: %s expected %h, actual %h",
                                $time, name, exp_v, act_v));
    end
endtask

task automatic compare_ptr(input string name, input logic [PTR_W-1:0] exp_v,
                           input logic [PTR_W-1:0] act_v);
    if (act_v !== exp_v) begin
        stop_on_error($sformatf("FAIL at %0t ns: %s expected %0d, actual %0d",
                                $time, name, exp_v, act_v));
    end
endtask

task automatic compare_flag(input string name, input logic exp_v, input logic act_v);
    if (act_v !== exp_v) begin
        stop_on_error($sformatf("FAIL at %0t ns: %s expected %b, actual %b",
                                $time, name, exp_v, act_v));
    end
endtask

task automatic compare_usage(input string name, input logic [USAGE_W-1:0] exp_v,
                             input logic [USAGE_W-1:0] act_v);
    if (act_v !== exp_v) begin
        stop_on_error($sformatf("FAIL at %0t ns: %s expected %0d, actual %0d",
                                $time, name, exp_v, act_v));
    end
endtask

// Looks for an offered entry at each falling edge, bounded by OFFER_TIMEOUT
task automatic wait_offer(output bit found);
    found = 1'b0;
    for (int i = 0; i < OFFER_TIMEOUT && !found; i++) begin
        @(negedge clk_i);
        found = pop_try_valid_o;
    end
endtask

`endif

// ==== verification/rtab_tb.sv ====
/*
 * Replay table testbench
 * Clock, reset, pattern file reader and command sequencer
 */
`timescale 1ns/10ps

module rtab_tb;
    import rtab_pkg::*;

    localparam int N_ENTRIES     = 4;
    localparam int PTR_W         = $clog2(N_ENTRIES);
    localparam int USAGE_W       = $clog2(N_ENTRIES + 1);
    localparam int OFFER_TIMEOUT = 50;
    localparam int DRIVE_DLY     = 10;

    logic               clk_i;
    logic               rst_ni;
    logic               alloc_i;
    logic               alloc_and_link_i;
    logic [NLINE_W-1:0] alloc_nline_i;
    logic [ID_W-1:0]    alloc_id_i;
    logic [DEP_W-1:0]   alloc_deps_i;
    logic               check_i;
    logic [NLINE_W-1:0] check_nline_i;
    logic               check_hit_o;
    logic               pop_try_valid_o;
    logic               pop_try_i;
    logic [NLINE_W-1:0] pop_try_nline_o;
    logic [ID_W-1:0]    pop_try_id_o;
    logic [PTR_W-1:0]   pop_try_ptr_o;
    logic               pop_commit_i;
    logic [PTR_W-1:0]   pop_commit_ptr_i;
    logic               pop_rback_i;
    logic [PTR_W-1:0]   pop_rback_ptr_i;
    logic               refill_i;
    logic [NLINE_W-1:0] refill_nline_i;
    logic               miss_ready_i;
    logic               empty_o;
    logic               full_o;
    logic [USAGE_W-1:0] usage_o;

    // Pattern reader state
    string              cmd;
    logic [8*128-1:0]   rest;
    int                 fd;
    int                 code;
    // Operands of the current command, read as hex
    int unsigned        op [4];

    // Expected slot of each live request
    bit                 slot_used [N_ENTRIES];
    logic [ID_W-1:0]    slot_id   [N_ENTRIES];

    `include "rtab_tb_checks.svh"

    rtab_top #(
        .N_ENTRIES (N_ENTRIES)
    ) dut_i (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    // Inputs change a fixed delay after the rising edge
    task automatic next_cycle();
        @(posedge clk_i);
        #(DRIVE_DLY);
    endtask

    task automatic read_operands(input int n);
        for (int k = 0; k < n; k++) begin
            code = $fscanf(fd, "%h", op[k]);
            if (code != 1) begin
                stop_on_error($sformatf("Pattern command %s is missing an operand", cmd));
            end
        end
    endtask

    // A new request lands in the lowest free slot
    task automatic record_alloc(input logic [ID_W-1:0] id);
        bit placed;
        placed = 1'b0;
        for (int s = 0; s < N_ENTRIES; s++) begin
            if (!slot_used[s] && !placed) begin
                slot_used[s] = 1'b1;
                slot_id[s]   = id;
                placed       = 1'b1;
            end
        end
    endtask

    function automatic logic [PTR_W-1:0] expected_slot(input logic [ID_W-1:0] id);
        logic [PTR_W-1:0] slot;
        slot = '0;
        for (int s = 0; s < N_ENTRIES; s++) begin
            if (slot_used[s] && (slot_id[s] == id)) begin
                slot = PTR_W'(s);
            end
        end
        return slot;
    endfunction

    // Plain allocation or link to the tail of the same line
    task automatic alloc_entry(input logic link);
        alloc_i          = !link;
        alloc_and_link_i = link;
        alloc_nline_i    = NLINE_W'(op[0]);
        alloc_id_i       = ID_W'(op[1]);
        alloc_deps_i     = DEP_W'(op[2]);
        check_i          = link;
        check_nline_i    = NLINE_W'(op[0]);
        if (link) begin
            @(negedge clk_i);
            compare_flag("check_hit_o", 1'b1, check_hit_o);
        end
        next_cycle();
        record_alloc(ID_W'(op[1]));
        alloc_i          = 1'b0;
        alloc_and_link_i = 1'b0;
        check_i          = 1'b0;
    endtask

    task automatic check_line();
        check_i       = 1'b1;
        check_nline_i = NLINE_W'(op[0]);
        @(negedge clk_i);
        compare_flag("check_hit_o", 1'(op[1]), check_hit_o);
        next_cycle();
        check_i = 1'b0;
    endtask

    // Takes the offered entry, then commits it or rolls it back with new deps
    task automatic pop_entry();
        bit               found;
        logic [PTR_W-1:0] ptr;
        logic [PTR_W-1:0] exp_ptr;
        exp_ptr = expected_slot(ID_W'(op[0]));
        wait_offer(found);
        if (!found) begin
            stop_on_error("Timeout: no entry was offered for pop within the wait limit");
        end
        next_cycle();
        pop_try_i = 1'b1;
        @(negedge clk_i);
        compare_flag("pop_try_valid_o", 1'b1, pop_try_valid_o);
        compare_id("pop_try_id_o", ID_W'(op[0]), pop_try_id_o);
        compare_nline("pop_try_nline_o", NLINE_W'(op[1]), pop_try_nline_o);
        compare_ptr("pop_try_ptr_o", exp_ptr, pop_try_ptr_o);
        ptr = pop_try_ptr_o;
        next_cycle();
        pop_try_i = 1'b0;
        if (op[2] != 0) begin
            pop_rback_i     = 1'b1;
            pop_rback_ptr_i = ptr;
            alloc_deps_i    = DEP_W'(op[3]);
        end else begin
            pop_commit_i       = 1'b1;
            pop_commit_ptr_i   = ptr;
            slot_used[exp_ptr] = 1'b0;
        end
        next_cycle();
        pop_rback_i  = 1'b0;
        pop_commit_i = 1'b0;
    endtask

    // Blocked entries keep the offer low for the whole wait
    task automatic expect_no_offer();
        bit found;
        wait_offer(found);
        compare_flag("pop_try_valid_o", 1'b0, pop_try_valid_o);
        next_cycle();
    endtask

    task automatic check_status();
        @(negedge clk_i);
        compare_flag("empty_o", 1'(op[0]), empty_o);
        compare_flag("full_o", 1'(op[1]), full_o);
        compare_usage("usage_o", USAGE_W'(op[2]), usage_o);
        next_cycle();
    endtask

    initial begin : sequencer
        rst_ni           = 1'b0;
        alloc_i          = 1'b0;
        alloc_and_link_i = 1'b0;
        alloc_nline_i    = '0;
        alloc_id_i       = '0;
        alloc_deps_i     = '0;
        check_i          = 1'b0;
        check_nline_i    = '0;
        pop_try_i        = 1'b0;
        pop_commit_i     = 1'b0;
        pop_commit_ptr_i = '0;
        pop_rback_i      = 1'b0;
        pop_rback_ptr_i  = '0;
        refill_i         = 1'b0;
        refill_nline_i   = '0;
        miss_ready_i     = 1'b0;
        repeat (4) @(posedge clk_i);
        #(DRIVE_DLY);
        rst_ni = 1'b1;

        fd = $fopen("verification/rtab_patterns.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open the pattern file verification/rtab_patterns.txt");
        end
        while ($fscanf(fd, "%s", cmd) == 1) begin
            case (cmd)
                "#": code = $fgets(rest, fd);
                "ALLOC": begin
                    read_operands(3);
                    alloc_entry(1'b0);
                end
                "LINK": begin
                    read_operands(3);
                    alloc_entry(1'b1);
                end
                "CHECK": begin
                    read_operands(2);
                    check_line();
                end
                "REFILL": begin
                    read_operands(1);
                    refill_i       = 1'b1;
                    refill_nline_i = NLINE_W'(op[0]);
                    next_cycle();
                    refill_i = 1'b0;
                end
                "MISSRDY": begin
                    miss_ready_i = 1'b1;
                    next_cycle();
                    miss_ready_i = 1'b0;
                end
                "POP": begin
                    read_operands(4);
                    pop_entry();
                end
                "NOPOP": expect_no_offer();
                "STATUS": begin
                    read_operands(3);
                    check_status();
                end
                default: stop_on_error($sformatf("Unknown pattern command %s", cmd));
            endcase
        end
        $fclose(fd);
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== verification/rtab_patterns.txt ====
# Replay table command patterns, operands in hex
# ALLOC/LINK nline id deps, CHECK nline hit, REFILL nline, MISSRDY, NOPOP
# POP id nline rback deps, STATUS empty full usage
STATUS 1 0 0
ALLOC 010 a1 0
ALLOC 020 a2 0
ALLOC 030 a3 0
ALLOC 040 a4 0
STATUS 0 1 4
CHECK 020 1
CHECK 050 0
POP a1 010 0 0
STATUS 0 0 3
CHECK 010 0
POP a2 020 0 0
STATUS 0 0 2
POP a3 030 0 0
POP a4 040 0 0
STATUS 1 0 0
# Refill dependency
ALLOC 100 11 1
NOPOP
REFILL 200
NOPOP
REFILL 100
POP 11 100 0 0
# Miss handler dependency
ALLOC 300 22 2
NOPOP
MISSRDY
POP 22 300 0 0
# Three requests on one line
ALLOC 400 31 0
LINK 400 32 0
LINK 400 33 0
STATUS 0 0 3
POP 31 400 0 0
POP 32 400 0 0
POP 33 400 0 0
STATUS 1 0 0
# Rollback without and with a refill dependency
ALLOC 500 41 0
POP 41 500 1 0
POP 41 500 1 1
NOPOP
REFILL 500
POP 41 500 0 0
STATUS 1 0 0

// ==== compile.f ====
+incdir+verification
src/rtab_pkg.sv
src/rtab_entry_store.sv
src/rtab_deps_tracker.sv
src/rtab_pop_ctrl.sv
src/rtab_top.sv
verification/rtab_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the replay table testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f compile.f --top-module rtab_tb -o rtab_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! sim_out="$(./obj_dir/rtab_sim 2>&1)"; then
    printf '%s\n' "$sim_out"
    echo "Simulation exited with an error"
    exit 1
fi
printf '%s\n' "$sim_out"

if grep -Fqx '** PASS **' <<< "$sim_out"; then
    exit 0
fi
echo "Pass line not found in the simulation output"
exit 1
